//--- hw/mc_core_pkg.sv
package mc_core_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb
    } core_state_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_imm;  // operand b from imm
        logic       branch_eq;
        logic       branch_ne;
        logic       jump;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       link;         // write pc + 4 to rd
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] alu_out;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] target;
        logic            take_branch;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic [4:0]      rd;
    } exec_res_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat;
        logic [3:0]      sel;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat;
    } wb_rsp_t;

endpackage

//--- hw/fetch_unit.sv
module fetch_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mc_core_pkg::core_state_e        state,
    input  logic [mc_core_pkg::xlen-1:0]    pc,
    output mc_core_pkg::wb_req_t            imem_req,
    input  mc_core_pkg::wb_rsp_t            imem_rsp,
    output logic [mc_core_pkg::xlen-1:0]    instr,
    output logic                            fetch_done
);

    logic req_q;
    logic start;

    // next fetch is launched at the end of writeback, or right after reset
    assign start = (state == mc_core_pkg::st_wb) ||
                   (state == mc_core_pkg::st_fetch && !req_q);

    assign fetch_done = req_q && imem_rsp.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (fetch_done) begin
            req_q <= 1'b0;  // drop cyc/stb the cycle after ack
        end else if (start) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= imem_rsp.dat;
        end
    end

    // pc only moves in writeback, so adr holds for the whole request
    assign imem_req = '{cyc: req_q, stb: req_q, we: 1'b0, adr: pc, dat: '0, sel: 4'hf};

endmodule

//--- hw/decode_unit.sv
module decode_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mc_core_pkg::core_state_e        state,
    input  logic [mc_core_pkg::xlen-1:0]    instr,
    output mc_core_pkg::ctrl_t              ctrl,
    output logic [mc_core_pkg::xlen-1:0]    imm
);

    localparam logic [6:0] op_imm  = 7'b0010011;
    localparam logic [6:0] op_reg  = 7'b0110011;
    localparam logic [6:0] op_lui  = 7'b0110111;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_stor = 7'b0100011;
    localparam logic [6:0] op_br   = 7'b1100011;
    localparam logic [6:0] op_jal  = 7'b1101111;

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    mc_core_pkg::ctrl_t             ctrl_d;
    logic [mc_core_pkg::xlen-1:0]   imm_d;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl_d     = '0;
        ctrl_d.rs1 = instr[19:15];
        ctrl_d.rs2 = instr[24:20];
        ctrl_d.rd  = instr[11:7];
        imm_d      = {{20{instr[31]}}, instr[31:20]};  // I-type
        case (opcode)
            op_imm: begin
                if (funct3 == 3'b000) begin  // addi only
                    ctrl_d.alu_src_imm = 1'b1;
                    ctrl_d.reg_write   = 1'b1;
                end
            end
            op_reg: begin
                ctrl_d.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl_d.alu_op = (funct7 == 7'b0100000) ? mc_core_pkg::alu_sub
                                                                   : mc_core_pkg::alu_add;
                    3'b111:  ctrl_d.alu_op = mc_core_pkg::alu_and;
                    3'b110:  ctrl_d.alu_op = mc_core_pkg::alu_or;
                    3'b100:  ctrl_d.alu_op = mc_core_pkg::alu_xor;
                    3'b010:  ctrl_d.alu_op = mc_core_pkg::alu_slt;
                    default: ctrl_d.reg_write = 1'b0;
                endcase
            end
            op_lui: begin
                ctrl_d.alu_op      = mc_core_pkg::alu_pass_b;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.reg_write   = 1'b1;
                imm_d              = {instr[31:12], 12'b0};
            end
            op_load: begin
                ctrl_d.alu_src_imm = (funct3 == 3'b010);  // lw only
                ctrl_d.mem_read    = (funct3 == 3'b010);
                ctrl_d.reg_write   = (funct3 == 3'b010);
            end
            op_stor: begin
                ctrl_d.alu_src_imm = (funct3 == 3'b010);
                ctrl_d.mem_write   = (funct3 == 3'b010);
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_br: begin
                ctrl_d.branch_eq = (funct3 == 3'b000);
                ctrl_d.branch_ne = (funct3 == 3'b001);
                imm_d = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            op_jal: begin
                ctrl_d.jump      = 1'b1;
                ctrl_d.link      = 1'b1;
                ctrl_d.reg_write = 1'b1;
                imm_d = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;  // no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (state == mc_core_pkg::st_decode) begin
            ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state == mc_core_pkg::st_decode) begin
            imm <= imm_d;
        end
    end

endmodule

//--- hw/exec_unit.sv
module exec_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mc_core_pkg::core_state_e        state,
    input  logic [mc_core_pkg::xlen-1:0]    pc,
    input  mc_core_pkg::ctrl_t              ctrl,
    input  logic [mc_core_pkg::xlen-1:0]    imm,
    input  logic [mc_core_pkg::xlen-1:0]    rs1_data,
    input  logic [mc_core_pkg::xlen-1:0]    rs2_data,
    output mc_core_pkg::exec_res_t          res
);

    logic [mc_core_pkg::xlen-1:0] op_b;
    logic [mc_core_pkg::xlen-1:0] alu_y;
    logic                         lt;
    logic                         eq;
    logic                         take;
    logic [mc_core_pkg::xlen-1:0] alu_q;
    logic [mc_core_pkg::xlen-1:0] store_q;
    logic [mc_core_pkg::xlen-1:0] target_q;
    logic [4:0]                   rd_q;
    logic                         take_q;
    logic                         mem_read_q;
    logic                         mem_write_q;
    logic                         reg_write_q;

    assign op_b = ctrl.alu_src_imm ? imm : rs2_data;
    assign lt   = $signed(rs1_data) < $signed(op_b);
    assign eq   = (rs1_data == rs2_data);
    assign take = ctrl.jump || (ctrl.branch_eq && eq) || (ctrl.branch_ne && !eq);

    always_comb begin
        case (ctrl.alu_op)
            mc_core_pkg::alu_sub:    alu_y = rs1_data - op_b;
            mc_core_pkg::alu_and:    alu_y = rs1_data & op_b;
            mc_core_pkg::alu_or:     alu_y = rs1_data | op_b;
            mc_core_pkg::alu_xor:    alu_y = rs1_data ^ op_b;
            mc_core_pkg::alu_slt:    alu_y = {{(mc_core_pkg::xlen-1){1'b0}}, lt};
            mc_core_pkg::alu_pass_b: alu_y = op_b;
            default:                 alu_y = rs1_data + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            take_q      <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
        end else if (state == mc_core_pkg::st_exec) begin
            take_q      <= take;
            mem_read_q  <= ctrl.mem_read;
            mem_write_q <= ctrl.mem_write;
            reg_write_q <= ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (state == mc_core_pkg::st_exec) begin
            alu_q    <= ctrl.link ? pc + 32'd4 : alu_y;  // jal link value
            store_q  <= rs2_data;
            target_q <= pc + imm;
            rd_q     <= ctrl.rd;
        end
    end

    assign res = '{alu_out: alu_q, store_data: store_q, target: target_q,
                   take_branch: take_q, mem_read: mem_read_q, mem_write: mem_write_q,
                   reg_write: reg_write_q, rd: rd_q};

endmodule

//--- hw/mem_stage.sv
module mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mc_core_pkg::core_state_e        state,
    input  mc_core_pkg::exec_res_t          res,
    output mc_core_pkg::wb_req_t            dmem_req,
    input  mc_core_pkg::wb_rsp_t            dmem_rsp,
    output logic                            mem_done,
    output logic                            wr_en,
    output logic [4:0]                      wr_addr,
    output logic [mc_core_pkg::xlen-1:0]    wr_data
);

    logic in_mem;
    logic is_access;
    logic req;

    assign in_mem    = (state == mc_core_pkg::st_mem);
    assign is_access = res.mem_read || res.mem_write;
    assign req       = in_mem && is_access;

    // non-memory instructions pass through st_mem in one cycle
    assign mem_done = !is_access || dmem_rsp.ack;

    assign dmem_req = '{cyc: req, stb: req, we: req && res.mem_write,
                        adr: res.alu_out, dat: res.store_data, sel: 4'hf};

    // wr_en is set on leaving st_mem, so it is high for exactly the st_wb cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_mem && mem_done && res.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (in_mem && mem_done) begin
            wr_data <= res.mem_read ? dmem_rsp.dat : res.alu_out;  // load data taken on ack
        end
    end

    assign wr_addr = res.rd;

endmodule

//--- hw/register_file.sv
module register_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [4:0]                      rs1,
    input  logic [4:0]                      rs2,
    output logic [mc_core_pkg::xlen-1:0]    rs1_data,
    output logic [mc_core_pkg::xlen-1:0]    rs2_data,
    input  logic                            wr_en,
    input  logic [4:0]                      wr_addr,
    input  logic [mc_core_pkg::xlen-1:0]    wr_data,
    output logic [mc_core_pkg::xlen-1:0]    dbg_x10
);

    logic [mc_core_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbg_x10  = regs[10];

endmodule

//--- hw/mc_core.sv
module mc_core #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output mc_core_pkg::wb_req_t    imem_req,
    input  mc_core_pkg::wb_rsp_t    imem_rsp,
    output mc_core_pkg::wb_req_t    dmem_req,
    input  mc_core_pkg::wb_rsp_t    dmem_rsp,
    output logic [31:0]             dbg_x10
);

    mc_core_pkg::core_state_e       state;
    logic [mc_core_pkg::xlen-1:0]   pc;
    logic [mc_core_pkg::xlen-1:0]   instr;
    logic                           fetch_done;
    mc_core_pkg::ctrl_t             ctrl;
    logic [mc_core_pkg::xlen-1:0]   imm;
    logic [mc_core_pkg::xlen-1:0]   rs1_data;
    logic [mc_core_pkg::xlen-1:0]   rs2_data;
    mc_core_pkg::exec_res_t         res;
    logic                           mem_done;
    logic                           wr_en;
    logic [4:0]                     wr_addr;
    logic [mc_core_pkg::xlen-1:0]   wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mc_core_pkg::st_fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                mc_core_pkg::st_fetch:  if (fetch_done) state <= mc_core_pkg::st_decode;
                mc_core_pkg::st_decode: state <= mc_core_pkg::st_exec;
                mc_core_pkg::st_exec:   state <= mc_core_pkg::st_mem;
                mc_core_pkg::st_mem:    if (mem_done) state <= mc_core_pkg::st_wb;
                mc_core_pkg::st_wb: begin
                    pc    <= res.take_branch ? res.target : pc + 32'd4;
                    state <= mc_core_pkg::st_fetch;
                end
                default: state <= mc_core_pkg::st_fetch;
            endcase
        end
    end

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .state(state), .pc(pc),
        .imem_req(imem_req), .imem_rsp(imem_rsp),
        .instr(instr), .fetch_done(fetch_done)
    );

    decode_unit u_decode (
        .clk(clk), .rst_n(rst_n), .state(state), .instr(instr),
        .ctrl(ctrl), .imm(imm)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .rs1(ctrl.rs1), .rs2(ctrl.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .dbg_x10(dbg_x10)
    );

    exec_unit u_exec (
        .clk(clk), .rst_n(rst_n), .state(state), .pc(pc), .ctrl(ctrl), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .res(res)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n), .state(state), .res(res),
        .dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .mem_done(mem_done),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

//--- dv/mc_core_props.sv
module mc_core_props (
    input logic                     clk,
    input logic                     rst_n,
    input mc_core_pkg::wb_req_t     imem_req,
    input mc_core_pkg::wb_rsp_t     imem_rsp,
    input mc_core_pkg::wb_req_t     dmem_req,
    input mc_core_pkg::wb_rsp_t     dmem_rsp,
    input mc_core_pkg::core_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;

    // master drops the request the cycle after ack
    imem_release: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_req.cyc && imem_rsp.ack) |=> !imem_req.cyc)
        else $error("instruction request held after ack");

    dmem_release: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req.cyc && dmem_rsp.ack) |=> !dmem_req.cyc)
        else $error("data request held after ack");

    // request must hold until the slave acks
    imem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_req.cyc && !imem_rsp.ack) |=> $stable(imem_req))
        else $error("instruction request changed before ack");

    dmem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req.cyc && !dmem_rsp.ack) |=> $stable(dmem_req))
        else $error("data request changed before ack");

    imem_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req.cyc |-> state == mc_core_pkg::st_fetch)
        else $error("instruction request outside the fetch state");

    wb_to_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        state == mc_core_pkg::st_wb |=> state == mc_core_pkg::st_fetch && imem_req.cyc)
        else $error("writeback not followed by a fetch request");

endmodule

bind mc_core mc_core_props u_props (
    .clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_rsp(imem_rsp),
    .dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .state(state)
);

//--- dv/tb_mc_core.sv
module tb_mc_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_pc = 32'h80;

    logic clk;
    logic rst_n;
    mc_core_pkg::wb_req_t imem_req;
    mc_core_pkg::wb_rsp_t imem_rsp;
    mc_core_pkg::wb_req_t dmem_req;
    mc_core_pkg::wb_rsp_t dmem_rsp;
    logic [31:0] dbg_x10;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] m_ram [0:255];  // model copy of the data RAM
    logic [31:0] m_regs [0:31];
    logic [31:0] exp_adr_q [$];
    logic [31:0] exp_dat_q [$];
    logic [31:0] lfsr = 32'hbc2cbd80;
    logic [31:0] exp_pc;
    logic [31:0] st_a;
    logic [31:0] st_d;
    logic st_flag;
    logic prev_cyc;
    logic halt_pending;
    logic done;
    int i_wait;
    int d_wait;
    int pp;
    int errors;
    int tests_failed;
    int cycles;
    int limit = 100000;

    mc_core #(.reset_pc(reset_pc)) DUT (
        .clk(clk), .rst_n(rst_n), .imem_req(imem_req), .imem_rsp(imem_rsp),
        .dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .dbg_x10(dbg_x10)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // reference ISA model that returns the next pc
    function automatic logic [31:0] ref_step(input logic [31:0] pc, output logic st,
                                             output logic [31:0] sa, output logic [31:0] sd);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ii;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [2:0] f3;
        logic wr;
        ins = rom[pc[9:2]];
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        f3 = ins[14:12];
        ii = {{20{ins[31]}}, ins[31:20]};
        st = 1'b0;
        sa = '0;
        sd = '0;
        wr = 1'b0;
        res = '0;
        nxt = pc + 4;
        case (ins[6:0])
            7'h13: begin
                wr = (f3 == 3'd0);
                res = a + ii;
            end
            7'h33: begin
                wr = 1'b1;
                case (f3)
                    3'd0: res = ins[30] ? a - b : a + b;
                    3'd7: res = a & b;
                    3'd6: res = a | b;
                    3'd4: res = a ^ b;
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    default: wr = 1'b0;
                endcase
            end
            7'h37: begin
                wr = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            7'h03: if (f3 == 3'd2) begin
                wr = 1'b1;
                sa = a + ii;
                res = m_ram[sa[9:2]];
            end
            7'h23: if (f3 == 3'd2) begin
                st = 1'b1;
                sa = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                sd = b;
                m_ram[sa[9:2]] = b;
            end
            7'h63: if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h6f: begin
                wr = 1'b1;
                res = pc + 4;  // link
                nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) m_regs[ins[11:7]] = res;
        return nxt;
    endfunction

    // instruction ROM slave
    always @(posedge clk) begin
        logic rst_seen;
        rst_seen = rst_n;  // reset as the DUT samples it on this edge
        #1;
        if (!rst_seen) begin
            imem_rsp = '0;
            i_wait = -1;
        end else if (imem_rsp.ack) begin
            imem_rsp.ack = 1'b0;
        end else if (imem_req.cyc && imem_req.stb) begin
            if (i_wait < 0) i_wait = int'(rand_bits(2));
            if (i_wait == 0) begin
                imem_rsp = '{ack: 1'b1, dat: rom[imem_req.adr[9:2]]};
                i_wait = -1;
            end else begin
                i_wait--;
            end
        end
    end

    // data RAM slave
    always @(posedge clk) begin
        logic rst_seen;
        rst_seen = rst_n;
        #1;
        if (!rst_seen) begin
            dmem_rsp = '0;
            d_wait = -1;
        end else if (dmem_rsp.ack) begin
            dmem_rsp.ack = 1'b0;
        end else if (dmem_req.cyc && dmem_req.stb) begin
            if (d_wait < 0) d_wait = int'(rand_bits(2));
            if (d_wait == 0) begin
                dmem_rsp = '{ack: 1'b1, dat: ram[dmem_req.adr[9:2]]};
                if (dmem_req.we) ram[dmem_req.adr[9:2]] = dmem_req.dat;
                d_wait = -1;
            end else begin
                d_wait--;
            end
        end
    end

    // compare fetch addresses and stores against the model
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_pc = reset_pc;
            prev_cyc = 1'b0;
            halt_pending = 1'b0;
            exp_adr_q.delete();
            exp_dat_q.delete();
            for (int k = 0; k < 32; k++) m_regs[k] = '0;
            for (int k = 0; k < 256; k++) m_ram[k] = ram[k];
        end else begin
            if (imem_req.cyc && !prev_cyc) begin
                check_val("imem_req.adr", exp_pc, imem_req.adr);
                if (halt_pending) begin
                    done = 1'b1;
                end else begin
                    exp_pc = ref_step(exp_pc, st_flag, st_a, st_d);
                    halt_pending = (rom[imem_req.adr[9:2]] == enc_j(21'd0, 5'd0));
                    if (st_flag) begin
                        exp_adr_q.push_back(st_a);
                        exp_dat_q.push_back(st_d);
                    end
                end
            end
            prev_cyc = imem_req.cyc;
            if (dmem_req.cyc && dmem_req.we && dmem_rsp.ack) begin
                if (exp_adr_q.size() == 0) begin
                    errors++;
                    $display("store at %0t that the model did not expect", $time);
                end else begin
                    check_val("dmem_req.adr", exp_adr_q.pop_front(), dmem_req.adr);
                    check_val("dmem_req.dat", exp_dat_q.pop_front(), dmem_req.dat);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("program did not finish");
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic emit(input logic [31:0] w);
        rom[pp] = w;
        pp++;
    endtask

    task automatic load_rand(input logic [4:0] rd);
        logic [31:0] w;
        w = rand_bits(32);
        emit({w[31:12], rd, 7'h37});
        emit(enc_i(w[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    task automatic clear_mem;
        for (int k = 0; k < 256; k++) begin
            rom[k] = {k[24:0], 7'h7f};  // unknown opcode tagged with its address
            ram[k] = k * 32'h9e3779b9;
        end
        pp = reset_pc >> 2;
    endtask

    task automatic build_alu;
        logic [6:0] f7s [6] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00};
        logic [2:0] f3s [6] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
        clear_mem();
        load_rand(1);
        load_rand(2);
        for (int k = 0; k < 6; k++) begin
            emit(enc_r(f7s[k], 2, 1, f3s[k], 3));
            emit(enc_s(12'h100 + 12'(k * 4), 3, 0));
        end
        emit(enc_r(7'h00, 1, 2, 3'd2, 3));  // slt with operands swapped
        emit(enc_s(12'h120, 3, 0));
        emit(enc_r(7'h00, 2, 1, 3'd4, 10));
        emit(enc_j(21'd0, 0));
    endtask

    task automatic run_program(input int id, input string name, input logic mid_reset);
        int err0;
        err0 = errors;
        done = 1'b0;
        limit = (pp - (reset_pc >> 2)) * 5 * 4 + 60;
        cycles = 0;
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        if (mid_reset) begin
            wait (dbg_x10 != '0);  // x10 is written late in the program
            @(posedge clk);
            #1 rst_n = 1'b0;
            @(posedge clk);
            @(negedge clk);
            check_val("imem_req.cyc", 0, 32'(imem_req.cyc));
            check_val("dmem_req.cyc", 0, 32'(dmem_req.cyc));
            check_val("dbg_x10", 0, dbg_x10);
            repeat (3) @(posedge clk);
            #1 rst_n = 1'b1;
            cycles = 0;
        end
        wait (done);
        @(negedge clk);
        check_val("dbg_x10", m_regs[10], dbg_x10);
        if (exp_adr_q.size() != 0) begin
            errors++;
            $display("expected stores never appeared on the data bus");
        end
        if (errors != err0) tests_failed++;
        $display("test %0d %s: %s", id, name, (errors == err0) ? "passed" : "failed");
    endtask

    initial begin
        rst_n = 1'b0;
        imem_rsp = '0;
        dmem_rsp = '0;
        errors = 0;
        tests_failed = 0;
        done = 1'b0;
        build_alu();
        run_program(1, "alu operations", 1'b0);
        clear_mem();
        emit(enc_i(12'h555, 0, 3'd0, 0, 7'h13));  // writes to x0
        emit(enc_i(12'd7, 0, 3'd0, 1, 7'h13));
        emit(enc_r(7'h00, 1, 1, 3'd0, 0));
        emit(enc_s(12'h40, 0, 0));
        emit(enc_r(7'h00, 1, 0, 3'd0, 10));
        emit(enc_j(21'd0, 0));
        run_program(2, "register zero", 1'b0);
        clear_mem();
        for (int k = 0; k < 4; k++) begin
            load_rand(5);
            emit(enc_s(12'h200 + 12'(k * 16), 5, 0));
            emit(enc_i(12'h200 + 12'(k * 16), 0, 3'd2, 6, 7'h03));
            emit(enc_s(12'h204 + 12'(k * 16), 6, 0));
            emit(enc_r(7'h00, 6, 10, 3'd0, 10));
        end
        emit(enc_j(21'd0, 0));
        run_program(3, "load store round trip", 1'b0);
        clear_mem();
        emit(enc_i(12'd3, 0, 3'd0, 1, 7'h13));
        emit(enc_i(12'd3, 0, 3'd0, 2, 7'h13));
        emit(enc_b(13'd8, 2, 1, 3'd0));  // taken
        emit(enc_i(12'd1, 10, 3'd0, 10, 7'h13));
        emit(enc_b(13'd8, 2, 1, 3'd1));  // not taken
        emit(enc_i(12'd2, 10, 3'd0, 10, 7'h13));
        emit(enc_b(13'd8, 0, 1, 3'd0));  // not taken
        emit(enc_i(12'd4, 10, 3'd0, 10, 7'h13));
        emit(enc_b(13'd8, 0, 1, 3'd1));  // taken
        emit(enc_i(12'd8, 10, 3'd0, 10, 7'h13));
        emit(enc_j(21'd0, 0));
        run_program(4, "branches", 1'b0);
        clear_mem();
        emit(enc_j(21'd8, 1));
        emit(enc_i(12'd1, 0, 3'd0, 10, 7'h13));
        emit(enc_s(12'h80, 1, 0));
        emit(enc_r(7'h00, 0, 1, 3'd0, 10));
        emit(32'h0000057f);  // unknown opcodes with rd = x10
        emit(32'h0000550b);
        emit(enc_s(12'h84, 10, 0));
        emit(enc_j(21'd0, 0));
        run_program(5, "jal and unknown opcode", 1'b0);
        build_alu();
        run_program(6, "reset mid-program", 1'b1);
        $display("tests 6, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- mc_core.f
hw/mc_core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/exec_unit.sv
hw/mem_stage.sv
hw/register_file.sv
hw/mc_core.sv
dv/mc_core_props.sv
dv/tb_mc_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mc_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mc_core \
    -f mc_core.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_mc_core > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
